/* verilog/bus_pkg.sv */
/*
  bus payload package
  request and response channel structs, opcodes and field widths
  of the single-word TL-UL style bus used by every block of the fabric
*/
package bus_pkg;

  // field widths of the request and response channels
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;
  localparam int unsigned src_w  = 4;

  // one mask bit per data byte
  localparam int unsigned mask_w = data_w / 8;

  // request opcodes, every access is one full 32-bit word
  typedef enum logic [1:0] {
    put_full    = 2'd0,
    put_partial = 2'd1,
    get         = 2'd2
  } a_op_e;

  // response opcodes, a put is acknowledged without data
  typedef enum logic [0:0] {
    access_ack      = 1'b0,
    access_ack_data = 1'b1
  } d_op_e;

  // request channel payload, 74 bits
  typedef struct packed {
    a_op_e               opcode;
    logic [addr_w-1:0]   address;
    logic [mask_w-1:0]   mask;
    logic [data_w-1:0]   data;
    logic [src_w-1:0]    source;
  } a_chan_t;

  // response channel payload, 38 bits
  // the source field echoes the source of the matching request
  typedef struct packed {
    d_op_e               opcode;
    logic                error;
    logic [data_w-1:0]   data;
    logic [src_w-1:0]    source;
  } d_chan_t;

endpackage

/* verilog/xbar_cfg_pkg.sv */
/*
  fabric configuration package
  device count, address map, host FIFO depths and the outstanding
  request limit of the one-host socket
*/
package xbar_cfg_pkg;

  // three local memories, the error device sits on the index after them
  localparam int unsigned n_dev = 3;
  localparam int unsigned sel_w = 2;
  localparam logic [sel_w-1:0] err_sel = 2'd3;

  // memory i decodes the range dev_base[i] up to dev_base[i] + dev_span
  localparam logic [n_dev-1:0][bus_pkg::addr_w-1:0] dev_base =
      {32'h0000_2000, 32'h0000_1000, 32'h0000_0000};
  localparam logic [bus_pkg::addr_w-1:0] dev_span = 32'h0000_1000;

  // each memory holds 64 words addressed by bits 7:2
  localparam int unsigned ram_words = 64;
  localparam int unsigned ram_aw    = 6;

  localparam int unsigned host_req_depth = 2;
  localparam int unsigned host_rsp_depth = 2;

  localparam int unsigned cnt_w = 4;
  localparam logic [cnt_w-1:0] max_outstanding = 4'd8;

endpackage

/* verilog/bus_fifo.sv */
/*
  bus FIFO
  synchronous valid/ready circular buffer whose payload type is a parameter,
  the head entry is driven from storage so a write shows up one cycle later
*/
`timescale 1ns/100ps

module bus_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned occ_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [occ_w-1:0] count;
  logic             push;
  logic             pop;

  // accept while there is a free slot, present the head while not empty
  assign in_ready_o  = (count != occ_w'(depth));
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // storage holds payload only
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  // pointers wrap at depth so any depth works, not only powers of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // a full or empty buffer has both pointers on the same slot
  ptr_match_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (count == '0 || count == occ_w'(depth)) |-> wr_ptr == rd_ptr);

  // the producer keeps an offered entry steady until it is taken
  in_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i));

endmodule

/* verilog/socket_steer.sv */
/*
  socket steering
  decodes the request address to a memory or to the error device, counts
  outstanding requests and holds a request to another device until every
  earlier response is back, so responses return in issue order
*/
`timescale 1ns/100ps

module socket_steer (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  input  bus_pkg::a_chan_t                      req_i,
  output logic [xbar_cfg_pkg::n_dev:0]          dev_a_valid_o,
  output bus_pkg::a_chan_t                      dev_a_o,
  input  logic [xbar_cfg_pkg::n_dev:0]          dev_a_ready_i,
  input  logic [xbar_cfg_pkg::n_dev:0]          dev_d_valid_i,
  input  bus_pkg::d_chan_t [xbar_cfg_pkg::n_dev:0] dev_d_i,
  output logic [xbar_cfg_pkg::n_dev:0]          dev_d_ready_o,
  output logic                                  rsp_valid_o,
  input  logic                                  rsp_ready_i,
  output bus_pkg::d_chan_t                      rsp_o
);

  logic [xbar_cfg_pkg::sel_w-1:0] sel;
  logic [xbar_cfg_pkg::sel_w-1:0] dev_q;
  logic [xbar_cfg_pkg::cnt_w-1:0] cnt_q;
  logic                           hold;
  logic                           acc_req;
  logic                           acc_rsp;

  // unmapped addresses fall through to the error device
  always_comb begin
    sel = xbar_cfg_pkg::err_sel;
    for (int i = 0; i < xbar_cfg_pkg::n_dev; i++) begin
      if (req_i.address >= xbar_cfg_pkg::dev_base[i] &&
          req_i.address < xbar_cfg_pkg::dev_base[i] + xbar_cfg_pkg::dev_span) begin
        sel = i[xbar_cfg_pkg::sel_w-1:0];
      end
    end
  end

  // switching devices waits for the pipe to drain, and the count is capped
  assign hold = ((cnt_q != '0) && (sel != dev_q)) ||
                (cnt_q == xbar_cfg_pkg::max_outstanding);

  // the payload goes to every device, only the selected one sees valid
  assign dev_a_o = req_i;

  always_comb begin
    for (int i = 0; i <= xbar_cfg_pkg::n_dev; i++) begin
      dev_a_valid_o[i] = req_valid_i & ~hold & (sel == i[xbar_cfg_pkg::sel_w-1:0]);
      dev_d_ready_o[i] = rsp_ready_i & (dev_q == i[xbar_cfg_pkg::sel_w-1:0]);
    end
  end

  // ready comes only from the addressed device
  assign req_ready_o = req_valid_i & ~hold & dev_a_ready_i[sel];

  // responses are taken only from the device that got the last request
  assign rsp_valid_o = dev_d_valid_i[dev_q];
  assign rsp_o       = dev_d_i[dev_q];

  assign acc_req = req_valid_i & req_ready_o;
  assign acc_rsp = rsp_valid_o & rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      dev_q <= '0;
    end else begin
      if (acc_req) begin
        dev_q <= sel;
      end
      if (acc_req && !acc_rsp) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (acc_rsp && !acc_req) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // the outstanding count never underflows
  cnt_no_wrap_down_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      acc_rsp && !acc_req |-> cnt_q != '0);

  // a device only answers a request this socket has handed it
  no_rsp_when_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_q == '0 |-> dev_d_valid_i == '0);

endmodule

/* verilog/bus_err_resp.sv */
/*
  error responder
  device behind every unmapped address, it takes any request and answers
  with the error bit set, zero data and the request's source id
*/
`timescale 1ns/100ps

module bus_err_resp (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             a_valid_i,
  output logic             a_ready_o,
  input  bus_pkg::a_chan_t a_i,
  output logic             d_valid_o,
  input  logic             d_ready_i,
  output bus_pkg::d_chan_t d_o
);

  logic             d_valid_q;
  bus_pkg::d_chan_t d_q;
  logic             accept;

  // one response register, a new request fits once the old answer leaves
  assign a_ready_o = ~d_valid_q | d_ready_i;
  assign accept    = a_valid_i & a_ready_o;

  // a get still expects a data beat, it just carries zero
  always_ff @(posedge clk_i) begin
    if (accept) begin
      d_q.opcode <= (a_i.opcode == bus_pkg::get) ? bus_pkg::access_ack_data :
                                                   bus_pkg::access_ack;
      d_q.error  <= 1'b1;
      d_q.data   <= '0;
      d_q.source <= a_i.source;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_valid_q <= 1'b0;
    end else if (accept) begin
      d_valid_q <= 1'b1;
    end else if (d_ready_i) begin
      d_valid_q <= 1'b0;
    end
  end

  assign d_valid_o = d_valid_q;
  assign d_o       = d_q;

endmodule

/* verilog/bus_ram.sv */
/*
  word memory device
  64-word memory with byte-masked puts, answers each request from a
  one-entry response register on the cycle after acceptance
*/
`timescale 1ns/100ps

module bus_ram (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             a_valid_i,
  output logic             a_ready_o,
  input  bus_pkg::a_chan_t a_i,
  output logic             d_valid_o,
  input  logic             d_ready_i,
  output bus_pkg::d_chan_t d_o
);

  logic [bus_pkg::data_w-1:0]      mem [xbar_cfg_pkg::ram_words];
  logic [xbar_cfg_pkg::ram_aw-1:0] idx;
  logic                            d_valid_q;
  bus_pkg::d_chan_t                d_q;
  logic                            accept;
  logic                            is_get;

  // word index inside the device window, bits above it were decoded upstream
  assign idx    = a_i.address[xbar_cfg_pkg::ram_aw+1:2];
  assign is_get = (a_i.opcode == bus_pkg::get);

  // stall while a response is pending and not being taken
  assign a_ready_o = ~d_valid_q | d_ready_i;
  assign accept    = a_valid_i & a_ready_o;

  // both put kinds honour the mask, a full put simply sets every bit
  always_ff @(posedge clk_i) begin
    if (accept && !is_get) begin
      for (int b = 0; b < bus_pkg::mask_w; b++) begin
        if (a_i.mask[b]) begin
          mem[idx][8*b +: 8] <= a_i.data[8*b +: 8];
        end
      end
    end
  end

  // a get reads the word before any write of the same cycle
  always_ff @(posedge clk_i) begin
    if (accept) begin
      d_q.opcode <= is_get ? bus_pkg::access_ack_data : bus_pkg::access_ack;
      d_q.error  <= 1'b0;
      d_q.data   <= is_get ? mem[idx] : '0;
      d_q.source <= a_i.source;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_valid_q <= 1'b0;
    end else if (accept) begin
      d_valid_q <= 1'b1;
    end else if (d_ready_i) begin
      d_valid_q <= 1'b0;
    end
  end

  assign d_valid_o = d_valid_q;
  assign d_o       = d_q;

  // the socket keeps an offered request steady until this memory takes it
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      a_valid_i && !a_ready_o |=> a_valid_i && $stable(a_i));

endmodule

/* verilog/bus_xbar_top.sv */
/*
  bus fabric top level
  host request and response FIFOs around the socket steering, which fans
  out to three word memories and the error responder
*/
`timescale 1ns/100ps

module bus_xbar_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             a_valid_i,
  output logic             a_ready_o,
  input  bus_pkg::a_chan_t a_i,
  output logic             d_valid_o,
  input  logic             d_ready_i,
  output bus_pkg::d_chan_t d_o
);

  // host side of the socket, after the request FIFO and before the response FIFO
  logic             req_valid;
  logic             req_ready;
  bus_pkg::a_chan_t req_data;
  logic             rsp_valid;
  logic             rsp_ready;
  bus_pkg::d_chan_t rsp_data;

  // device side, memories on the low indices and the error device last
  logic [xbar_cfg_pkg::n_dev:0]             dev_a_valid;
  logic [xbar_cfg_pkg::n_dev:0]             dev_a_ready;
  bus_pkg::a_chan_t                         dev_a;
  logic [xbar_cfg_pkg::n_dev:0]             dev_d_valid;
  logic [xbar_cfg_pkg::n_dev:0]             dev_d_ready;
  bus_pkg::d_chan_t [xbar_cfg_pkg::n_dev:0] dev_d;

  bus_fifo #(
    .payload_t (bus_pkg::a_chan_t),
    .depth     (xbar_cfg_pkg::host_req_depth)
  ) u_req_fifo (
    .clk_i,
    .rst_ni,
    .in_valid_i  (a_valid_i),
    .in_ready_o  (a_ready_o),
    .in_data_i   (a_i),
    .out_valid_o (req_valid),
    .out_ready_i (req_ready),
    .out_data_o  (req_data)
  );

  socket_steer u_steer (
    .clk_i,
    .rst_ni,
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .req_i         (req_data),
    .dev_a_valid_o (dev_a_valid),
    .dev_a_o       (dev_a),
    .dev_a_ready_i (dev_a_ready),
    .dev_d_valid_i (dev_d_valid),
    .dev_d_i       (dev_d),
    .dev_d_ready_o (dev_d_ready),
    .rsp_valid_o   (rsp_valid),
    .rsp_ready_i   (rsp_ready),
    .rsp_o         (rsp_data)
  );

  // one memory per mapped window, the request payload is shared by all
  bus_ram u_ram [xbar_cfg_pkg::n_dev-1:0] (
    .clk_i,
    .rst_ni,
    .a_valid_i (dev_a_valid[xbar_cfg_pkg::n_dev-1:0]),
    .a_ready_o (dev_a_ready[xbar_cfg_pkg::n_dev-1:0]),
    .a_i       (dev_a),
    .d_valid_o (dev_d_valid[xbar_cfg_pkg::n_dev-1:0]),
    .d_ready_i (dev_d_ready[xbar_cfg_pkg::n_dev-1:0]),
    .d_o       (dev_d[xbar_cfg_pkg::n_dev-1:0])
  );

  bus_err_resp u_err (
    .clk_i,
    .rst_ni,
    .a_valid_i (dev_a_valid[xbar_cfg_pkg::n_dev]),
    .a_ready_o (dev_a_ready[xbar_cfg_pkg::n_dev]),
    .a_i       (dev_a),
    .d_valid_o (dev_d_valid[xbar_cfg_pkg::n_dev]),
    .d_ready_i (dev_d_ready[xbar_cfg_pkg::n_dev]),
    .d_o       (dev_d[xbar_cfg_pkg::n_dev])
  );

  bus_fifo #(
    .payload_t (bus_pkg::d_chan_t),
    .depth     (xbar_cfg_pkg::host_rsp_depth)
  ) u_rsp_fifo (
    .clk_i,
    .rst_ni,
    .in_valid_i  (rsp_valid),
    .in_ready_o  (rsp_ready),
    .in_data_i   (rsp_data),
    .out_valid_o (d_valid_o),
    .out_ready_i (d_ready_i),
    .out_data_o  (d_o)
  );

endmodule

/* bench/tb_bus_xbar.sv */
/*
  testbench for the bus fabric top level
  runs a table of requests through the host port, checks every response in
  issue order against hand values and a reference memory model, and adds
  random back-pressure on the response channel in the last test
*/
`timescale 1ns/100ps

module tb_bus_xbar;

  // one table row is a request plus the response it should produce
  typedef struct packed {
    logic [2:0]     test;
    bus_pkg::a_op_e op;
    logic [31:0]    addr;
    logic [3:0]     mask;
    logic [31:0]    data;
    logic [3:0]     src;
    logic [31:0]    exp_data;
    logic           exp_err;
  } row_t;

  logic             clk_i;
  logic             rst_ni;
  logic             a_valid_i;
  logic             a_ready_o;
  bus_pkg::a_chan_t a_i;
  logic             d_valid_o;
  logic             d_ready_i;
  bus_pkg::d_chan_t d_o;

  row_t        rows [$];
  row_t        sent_q [$];
  logic [31:0] ref_mem [3][64];
  bit          ref_set [3][64];
  int          seed = 32'h4914;
  bit          bp_on;
  bit          table_ready;
  int          rcv_count;
  int          other_err;
  int          test_rows [1:5];
  int          test_done [1:5];
  int          test_err [1:5];
  string       test_name [1:5] = '{"write/read", "partial put", "unmapped",
                                   "alternating", "back-pressure"};

  bus_xbar_top UUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid_i (a_valid_i),
    .a_ready_o (a_ready_o),
    .a_i       (a_i),
    .d_valid_o (d_valid_o),
    .d_ready_i (d_ready_i),
    .d_o       (d_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // the memory map is 0x0000, 0x1000 and 0x2000 with 64 words each,
  // a word sits on address bits 7:2 and anything from 0x3000 up is unmapped
  task automatic model_access(input bus_pkg::a_op_e op, input logic [31:0] addr,
      input logic [3:0] mask, input logic [31:0] data,
      output logic [31:0] rd, output logic err);
    logic [1:0] dev;
    logic [5:0] word;
    dev  = addr[13:12];
    word = addr[7:2];
    rd   = '0;
    err  = (addr >= 32'h0000_3000);
    if (!err && op == bus_pkg::get) begin
      rd = ref_mem[dev][word];
    end else if (!err) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          ref_mem[dev][word][8*b +: 8] = data[8*b +: 8];
        end
      end
      if (mask == 4'hf) begin
        ref_set[dev][word] = 1'b1;
      end
    end
  endtask

  // source ids follow the row index, so neighbouring rows never share one
  task automatic add_row(input logic [2:0] test, input bus_pkg::a_op_e op,
      input logic [31:0] addr, input logic [3:0] mask, input logic [31:0] data,
      input logic [31:0] exp_data, input logic exp_err);
    row_t r;
    r.test     = test;
    r.op       = op;
    r.addr     = addr;
    r.mask     = mask;
    r.data     = data;
    r.src      = 4'(rows.size());
    r.exp_data = exp_data;
    r.exp_err  = exp_err;
    rows.push_back(r);
    test_rows[test]++;
  endtask

  // hand-written rows still pass through the model to keep its state current
  task automatic add_directed(input logic [2:0] test, input bus_pkg::a_op_e op,
      input logic [31:0] addr, input logic [3:0] mask, input logic [31:0] data,
      input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    model_access(op, addr, mask, data, rd, err);
    add_row(test, op, addr, mask, data, exp_data, exp_err);
  endtask

  // words 0..7 of each memory plus the unmapped 0x3000 window
  task automatic add_random_rows(input int n);
    logic [31:0]    rnd;
    logic [31:0]    wdata;
    logic [31:0]    addr;
    logic [3:0]     mask;
    logic [31:0]    rd;
    logic           err;
    bus_pkg::a_op_e op;
    for (int k = 0; k < n; k++) begin
      rnd   = $random(seed);
      wdata = $random(seed);
      addr  = {18'd0, rnd[1:0], 7'd0, rnd[4:2], 2'b00};
      mask  = rnd[10:7];
      case (rnd[6:5])
        2'd0:    op = bus_pkg::put_full;
        2'd1:    op = bus_pkg::put_partial;
        default: op = bus_pkg::get;
      endcase
      // a word that was never fully written would read back unknown bytes
      if (rnd[1:0] != 2'd3 && !ref_set[rnd[1:0]][rnd[4:2]]) begin
        op = bus_pkg::put_full;
      end
      if (op == bus_pkg::put_full) begin
        mask = 4'hf;
      end
      model_access(op, addr, mask, wdata, rd, err);
      add_row(3'd5, op, addr, mask, wdata, rd, err);
    end
  endtask

  function automatic bus_pkg::a_chan_t to_req(input row_t r);
    bus_pkg::a_chan_t a;
    a.opcode  = r.op;
    a.address = r.addr;
    a.mask    = r.mask;
    a.data    = r.data;
    a.source  = r.src;
    return a;
  endfunction

  task automatic log_mismatch(input string sig, input logic [31:0] got,
      input logic [31:0] exp, input logic [2:0] test);
    $display("ERR t=%0t %s got=0x%08h expected=0x%08h", $time, sig, got, exp);
    test_err[test]++;
  endtask

  // a put is acknowledged without data, a get with it, errors or not
  task automatic check_response(input row_t r);
    bus_pkg::d_op_e exp_op;
    exp_op = (r.op == bus_pkg::get) ? bus_pkg::access_ack_data : bus_pkg::access_ack;
    assert (d_o.opcode == exp_op)
      else log_mismatch("d_o.opcode", 32'(d_o.opcode), 32'(exp_op), r.test);
    assert (d_o.error == r.exp_err)
      else log_mismatch("d_o.error", 32'(d_o.error), 32'(r.exp_err), r.test);
    assert (d_o.data == r.exp_data)
      else log_mismatch("d_o.data", d_o.data, r.exp_data, r.test);
    assert (d_o.source == r.src)
      else log_mismatch("d_o.source", 32'(d_o.source), 32'(r.src), r.test);
    test_done[r.test]++;
    if (test_done[r.test] == test_rows[r.test]) begin
      $display("test %0d %s done: %0d responses, %0d errors", r.test,
               test_name[r.test], test_done[r.test], test_err[r.test]);
    end
  endtask

  // response ready toggles randomly only while the last test is running
  initial begin
    d_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      if (bp_on) begin
        d_ready_i <= (($random(seed) % 3) != 0);
      end else begin
        d_ready_i <= 1'b1;
      end
    end
  end

  // a transfer is due at the next rising edge, so negedge values are settled
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && d_valid_o && d_ready_i) begin
        assert (sent_q.size() != 0) else begin
          $display("response at t=%0t with no request outstanding", $time);
          other_err++;
        end
        if (sent_q.size() != 0) begin
          check_response(sent_q.pop_front());
          rcv_count++;
        end
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (rows.size() * 20 + 200) @(posedge clk_i);
    $display("timeout: only %0d of %0d responses came back", rcv_count, rows.size());
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int total;
    rst_ni    = 1'b0;
    a_valid_i = 1'b0;
    a_i       = '0;

    // test 1 writes then reads one word in every memory
    add_directed(3'd1, bus_pkg::put_full, 32'h0000_0010, 4'hf, 32'h1111_1111, 32'h0, 1'b0);
    add_directed(3'd1, bus_pkg::get, 32'h0000_0010, 4'hf, 32'h0, 32'h1111_1111, 1'b0);
    add_directed(3'd1, bus_pkg::put_full, 32'h0000_1010, 4'hf, 32'h2222_2222, 32'h0, 1'b0);
    add_directed(3'd1, bus_pkg::get, 32'h0000_1010, 4'hf, 32'h0, 32'h2222_2222, 1'b0);
    add_directed(3'd1, bus_pkg::put_full, 32'h0000_2010, 4'hf, 32'h3333_3333, 32'h0, 1'b0);
    add_directed(3'd1, bus_pkg::get, 32'h0000_2010, 4'hf, 32'h0, 32'h3333_3333, 1'b0);
    // bytes 0 and 2 first, then byte 3 on top of the merged word
    add_directed(3'd2, bus_pkg::put_full, 32'h0000_1020, 4'hf, 32'h1234_5678, 32'h0, 1'b0);
    add_directed(3'd2, bus_pkg::put_partial, 32'h0000_1020, 4'h5, 32'hAABB_CCDD, 32'h0, 1'b0);
    add_directed(3'd2, bus_pkg::get, 32'h0000_1020, 4'hf, 32'h0, 32'h12BB_56DD, 1'b0);
    add_directed(3'd2, bus_pkg::put_partial, 32'h0000_1020, 4'h8, 32'hEE00_0000, 32'h0, 1'b0);
    add_directed(3'd2, bus_pkg::get, 32'h0000_1020, 4'hf, 32'h0, 32'hEEBB_56DD, 1'b0);
    add_directed(3'd3, bus_pkg::get, 32'h0000_4000, 4'hf, 32'h0, 32'h0, 1'b1);
    add_directed(3'd3, bus_pkg::put_full, 32'h8000_0000, 4'hf, 32'hDEAD_BEEF, 32'h0, 1'b1);
    add_directed(3'd3, bus_pkg::get, 32'h0000_0010, 4'hf, 32'h0, 32'h1111_1111, 1'b0);
    // every row here switches device, so the socket drains between them
    add_directed(3'd4, bus_pkg::get, 32'h0000_0010, 4'hf, 32'h0, 32'h1111_1111, 1'b0);
    add_directed(3'd4, bus_pkg::get, 32'h0000_1010, 4'hf, 32'h0, 32'h2222_2222, 1'b0);
    add_directed(3'd4, bus_pkg::get, 32'h0000_2010, 4'hf, 32'h0, 32'h3333_3333, 1'b0);
    add_directed(3'd4, bus_pkg::get, 32'h0000_0010, 4'hf, 32'h0, 32'h1111_1111, 1'b0);
    add_directed(3'd4, bus_pkg::put_full, 32'h0000_3000, 4'hf, 32'h5555_5555, 32'h0, 1'b1);
    add_directed(3'd4, bus_pkg::get, 32'h0000_1020, 4'hf, 32'h0, 32'hEEBB_56DD, 1'b0);
    add_random_rows(60);
    table_ready = 1'b1;

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (d_valid_o == 1'b0)
      else log_mismatch("d_valid_o", 32'(d_valid_o), 32'h0, 3'd1);
    assert (a_ready_o == 1'b1)
      else log_mismatch("a_ready_o", 32'(a_ready_o), 32'h1, 3'd1);

    @(posedge clk_i);
    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].test == 3'd5) begin
        bp_on = 1'b1;
      end
      a_valid_i <= 1'b1;
      a_i       <= to_req(rows[i]);
      @(negedge clk_i);
      while (!a_ready_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
      sent_q.push_back(rows[i]);
    end
    a_valid_i <= 1'b0;

    wait (rcv_count == rows.size());
    repeat (20) @(posedge clk_i);
    total = other_err;
    for (int t = 1; t <= 5; t++) begin
      total += test_err[t];
    end
    $display("summary: %0d rows, %0d responses, %0d errors", rows.size(), rcv_count, total);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* bus_xbar.f */
verilog/bus_pkg.sv
verilog/xbar_cfg_pkg.sv
verilog/bus_fifo.sv
verilog/socket_steer.sv
verilog/bus_err_resp.sv
verilog/bus_ram.sv
verilog/bus_xbar_top.sv
bench/tb_bus_xbar.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_bus_xbar
FILELIST = bus_xbar.f
BUILD    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
